// ==== bus_addr_decode.sv ====
module bus_addr_decode #(
    parameter int                  NMST = 2,
    parameter int                  NSLV = 3,
    parameter bus_pkg::map_entry_t P_MAP [NSLV] = '{default: '0}
) (
    input  logic [bus_pkg::ADDR_W-1:0]   i_addr,
    output logic [$clog2(NSLV+1)-1:0]    o_sidx
);

    localparam int ADDR_W = bus_pkg::ADDR_W;
    localparam int LSB    = bus_pkg::PAGE_LSB;
    localparam int SIDX_W = $clog2(NSLV + 1);

    logic [ADDR_W-1:LSB] page;

    // Reject configurations the interconnect cannot route
    if (NMST < 1 || NSLV < 1) begin : g_bad_cfg
        $error("bus_addr_decode needs at least one master and one slave");
    end

    assign page = i_addr[ADDR_W-1:LSB];

    // Last matching window wins, no match selects the default slave
    always_comb begin
        o_sidx = SIDX_W'(NSLV);
        for (int s = 0; s < NSLV; s++) begin
            if (page >= P_MAP[s].addr_start[ADDR_W-1:LSB] &&
                page <  P_MAP[s].addr_end[ADDR_W-1:LSB]) begin
                o_sidx = SIDX_W'(s);
            end
        end
    end

endmodule

// ==== bus_chan_if.sv ====
interface bus_chan_if #(
    parameter int ADDR_W = bus_pkg::ADDR_W,
    parameter int DATA_W = bus_pkg::DATA_W
) ();

    localparam int STRB_W = DATA_W / 8;

    // Request channel
    logic              req_valid;
    logic              req_ready;
    logic              req_write;
    logic [ADDR_W-1:0] req_addr;
    logic [DATA_W-1:0] req_wdata;
    logic [STRB_W-1:0] req_wstrb;

    // Response channel
    logic              resp_valid;
    logic              resp_ready;
    logic [DATA_W-1:0] resp_rdata;
    logic              resp_err;

    // Side that issues requests
    modport mst (
        output req_valid, req_write, req_addr, req_wdata, req_wstrb, resp_ready,
        input  req_ready, resp_valid, resp_rdata, resp_err
    );

    // Side that serves requests
    modport slv (
        input  req_valid, req_write, req_addr, req_wdata, req_wstrb, resp_ready,
        output req_ready, resp_valid, resp_rdata, resp_err
    );

endinterface

// ==== bus_miss_resp.sv ====
module bus_miss_resp #(
    parameter int NMST = 2,
    parameter int NSLV = 3
) (
    input  logic    i_clk,
    input  logic    i_nrst,
    bus_chan_if.slv i_req
);

    logic req_fire;
    logic resp_fire;

    // Error response waiting for the master
    logic r_pending;

    // The miss path only exists next to real masters and slaves
    if (NMST < 1 || NSLV < 1) begin : g_bad_cfg
        $error("bus_miss_resp needs at least one master and one slave");
    end

    // One request at a time, accepted only with nothing pending
    assign i_req.req_ready = ~r_pending;

    assign req_fire  = i_req.req_valid & ~r_pending;
    assign resp_fire = r_pending & i_req.resp_ready;

    // Reads and writes get the same answer, write data is dropped
    assign i_req.resp_valid = r_pending;
    assign i_req.resp_rdata = bus_pkg::MISS_RDATA;
    assign i_req.resp_err   = bus_pkg::MISS_ERR;

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            r_pending <= 1'b0;
        end else if (req_fire) begin
            r_pending <= 1'b1;
        end else if (resp_fire) begin
            r_pending <= 1'b0;
        end
    end

endmodule

// ==== bus_pkg.sv ====
package bus_pkg;

    // Bus widths
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int STRB_W = DATA_W / 8;

    // Lowest address bit taken into the map compare, 4 KB pages
    localparam int PAGE_LSB = 12;

    // One mapped window
    // start page is part of the window, end page is not
    typedef struct packed {
        logic [ADDR_W-1:0] addr_start;
        logic [ADDR_W-1:0] addr_end;
    } map_entry_t;

    // Answer of the default slave for unmapped accesses
    localparam logic [DATA_W-1:0] MISS_RDATA = '1;
    localparam logic              MISS_ERR   = 1'b1;

endpackage

// ==== bus_route_ctrl.sv ====
module bus_route_ctrl #(
    parameter int NMST = 2,
    parameter int NSLV = 3
) (
    input  logic                        i_clk,
    input  logic                        i_nrst,
    bus_chan_if.slv                     i_mst [NMST],
    bus_chan_if.mst                     o_slv [NSLV+1],
    output logic [bus_pkg::ADDR_W-1:0]  o_req_addr,
    input  logic [$clog2(NSLV+1)-1:0]   i_sidx
);

    localparam int ADDR_W = bus_pkg::ADDR_W;
    localparam int DATA_W = bus_pkg::DATA_W;
    localparam int STRB_W = bus_pkg::STRB_W;
    localparam int MIDX_W = (NMST > 1) ? $clog2(NMST) : 1;
    localparam int SIDX_W = $clog2(NSLV + 1);

    // Master side, flattened from the interface array
    logic [NMST-1:0]   mst_req_valid;
    logic [NMST-1:0]   mst_req_write;
    logic [ADDR_W-1:0] mst_req_addr  [NMST];
    logic [DATA_W-1:0] mst_req_wdata [NMST];
    logic [STRB_W-1:0] mst_req_wstrb [NMST];
    logic [NMST-1:0]   mst_resp_ready;
    logic [NMST-1:0]   mst_req_ready;
    logic [NMST-1:0]   mst_resp_valid;

    // Slave side, last entry is the default slave
    logic [NSLV:0]     slv_req_ready;
    logic [NSLV:0]     slv_resp_valid;
    logic [DATA_W-1:0] slv_resp_rdata [NSLV+1];
    logic [NSLV:0]     slv_resp_err;
    logic [NSLV:0]     slv_req_valid;
    logic [NSLV:0]     slv_resp_ready;

    logic              any_req;
    logic [MIDX_W-1:0] win_midx;
    logic              req_fire;
    logic              resp_fire;

    // Owner of the transaction in flight
    logic              r_busy;
    logic [MIDX_W-1:0] r_midx;
    logic [SIDX_W-1:0] r_sidx;

    for (genvar m = 0; m < NMST; m++) begin : g_mst
        assign mst_req_valid[m]    = i_mst[m].req_valid;
        assign mst_req_write[m]    = i_mst[m].req_write;
        assign mst_req_addr[m]     = i_mst[m].req_addr;
        assign mst_req_wdata[m]    = i_mst[m].req_wdata;
        assign mst_req_wstrb[m]    = i_mst[m].req_wstrb;
        assign mst_resp_ready[m]   = i_mst[m].resp_ready;
        assign i_mst[m].req_ready  = mst_req_ready[m];
        assign i_mst[m].resp_valid = mst_resp_valid[m];
        // Response payload goes to every master, valid only to the owner
        assign i_mst[m].resp_rdata = slv_resp_rdata[r_sidx];
        assign i_mst[m].resp_err   = slv_resp_err[r_sidx];
    end

    for (genvar s = 0; s <= NSLV; s++) begin : g_slv
        assign slv_req_ready[s]    = o_slv[s].req_ready;
        assign slv_resp_valid[s]   = o_slv[s].resp_valid;
        assign slv_resp_rdata[s]   = o_slv[s].resp_rdata;
        assign slv_resp_err[s]     = o_slv[s].resp_err;
        assign o_slv[s].req_valid  = slv_req_valid[s];
        assign o_slv[s].resp_ready = slv_resp_ready[s];
        // Request payload is shared, only valid selects the slave
        assign o_slv[s].req_write  = mst_req_write[win_midx];
        assign o_slv[s].req_addr   = mst_req_addr[win_midx];
        assign o_slv[s].req_wdata  = mst_req_wdata[win_midx];
        assign o_slv[s].req_wstrb  = mst_req_wstrb[win_midx];
    end

    // Highest-numbered requesting master wins
    always_comb begin
        any_req  = 1'b0;
        win_midx = '0;
        for (int m = 0; m < NMST; m++) begin
            if (mst_req_valid[m]) begin
                any_req  = 1'b1;
                win_midx = MIDX_W'(m);
            end
        end
    end

    assign o_req_addr = mst_req_addr[win_midx];

    // Request path is closed while a transaction is in flight
    always_comb begin
        mst_req_ready = '0;
        slv_req_valid = '0;
        slv_req_valid[i_sidx]   = any_req & ~r_busy;
        mst_req_ready[win_midx] = any_req & ~r_busy & slv_req_ready[i_sidx];
    end

    always_comb begin
        mst_resp_valid = '0;
        slv_resp_ready = '0;
        if (r_busy) begin
            mst_resp_valid[r_midx] = slv_resp_valid[r_sidx];
            slv_resp_ready[r_sidx] = mst_resp_ready[r_midx];
        end
    end

    assign req_fire  = any_req & ~r_busy & slv_req_ready[i_sidx];
    assign resp_fire = r_busy & slv_resp_valid[r_sidx] & mst_resp_ready[r_midx];

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            r_busy <= 1'b0;
            r_midx <= '0;
            r_sidx <= '0;
        end else if (req_fire) begin
            r_busy <= 1'b1;
            r_midx <= win_midx;
            r_sidx <= i_sidx;
        end else if (resp_fire) begin
            r_busy <= 1'b0;
        end
    end

endmodule

// ==== bus_xbar_props.sv ====
module bus_xbar_props #(
    parameter int NMST   = 2,
    parameter int NSLV   = 3,
    parameter int MIDX_W = (NMST > 1) ? $clog2(NMST) : 1,
    parameter int SIDX_W = $clog2(NSLV + 1)
) (
    input logic              i_clk,
    input logic              i_nrst,
    input logic              i_busy,
    input logic [MIDX_W-1:0] i_midx,
    input logic [SIDX_W-1:0] i_sidx,
    input logic [MIDX_W-1:0] i_win_midx,
    input logic [SIDX_W-1:0] i_dec_sidx,
    input logic              i_req_fire,
    input logic              i_resp_fire,
    input logic [NSLV:0]     i_slv_req_valid
);

    // Number of failed assertions
    int fail_cnt = 0;

    // Request fire takes the winner and the decoded slave as owner
    a_req_sets_owner: assert property (@(posedge i_clk) disable iff (!i_nrst)
        i_req_fire |=> i_busy && i_midx == $past(i_win_midx) && i_sidx == $past(i_dec_sidx))
        else begin
            $error("request fire did not register the owner pair");
            fail_cnt++;
        end

    // Response fire frees the owner for the next request
    a_resp_clears_owner: assert property (@(posedge i_clk) disable iff (!i_nrst)
        i_resp_fire |=> !i_busy)
        else begin
            $error("owner still set after a response fire");
            fail_cnt++;
        end

    // Owner pair stays put until its response fires
    a_owner_held: assert property (@(posedge i_clk) disable iff (!i_nrst)
        i_busy && !i_resp_fire |=> i_busy && $stable(i_midx) && $stable(i_sidx))
        else begin
            $error("owner changed without a response fire");
            fail_cnt++;
        end

    a_idle_held: assert property (@(posedge i_clk) disable iff (!i_nrst)
        !i_busy && !i_req_fire |=> !i_busy)
        else begin
            $error("owner set without a request fire");
            fail_cnt++;
        end

    a_one_slave: assert property (@(posedge i_clk) disable iff (!i_nrst)
        $onehot0(i_slv_req_valid))
        else begin
            $error("more than one slave sees req_valid");
            fail_cnt++;
        end

endmodule

bind bus_route_ctrl bus_xbar_props #(
    .NMST (NMST),
    .NSLV (NSLV)
) u_props (
    .i_clk           (i_clk),
    .i_nrst          (i_nrst),
    .i_busy          (r_busy),
    .i_midx          (r_midx),
    .i_sidx          (r_sidx),
    .i_win_midx      (win_midx),
    .i_dec_sidx      (i_sidx),
    .i_req_fire      (req_fire),
    .i_resp_fire     (resp_fire),
    .i_slv_req_valid (slv_req_valid)
);

// ==== bus_xbar_top.f ====
+incdir+.
bus_pkg.sv
bus_chan_if.sv
bus_addr_decode.sv
bus_route_ctrl.sv
bus_miss_resp.sv
bus_xbar_top.sv
bus_xbar_props.sv
tb_bus_xbar.sv

// ==== bus_xbar_top.sv ====
module bus_xbar_top #(
    parameter int                  NMST = 2,
    parameter int                  NSLV = 3,
    parameter bus_pkg::map_entry_t P_MAP [NSLV] = '{
        '{addr_start: 32'h0000_0000, addr_end: 32'h0001_0000},
        '{addr_start: 32'h0001_0000, addr_end: 32'h0002_0000},
        '{addr_start: 32'h8000_0000, addr_end: 32'h8000_1000}
    }
) (
    input  logic                                i_clk,
    input  logic                                i_nrst,

    // Masters
    input  logic [NMST-1:0]                     i_m_req_valid,
    input  logic [NMST-1:0]                     i_m_req_write,
    input  logic [NMST*bus_pkg::ADDR_W-1:0]     i_m_req_addr,
    input  logic [NMST*bus_pkg::DATA_W-1:0]     i_m_req_wdata,
    input  logic [NMST*bus_pkg::STRB_W-1:0]     i_m_req_wstrb,
    input  logic [NMST-1:0]                     i_m_resp_ready,
    output logic [NMST-1:0]                     o_m_req_ready,
    output logic [NMST-1:0]                     o_m_resp_valid,
    output logic [NMST*bus_pkg::DATA_W-1:0]     o_m_resp_rdata,
    output logic [NMST-1:0]                     o_m_resp_err,

    // Mapped slaves
    output logic [NSLV-1:0]                     o_s_req_valid,
    output logic [NSLV-1:0]                     o_s_req_write,
    output logic [NSLV*bus_pkg::ADDR_W-1:0]     o_s_req_addr,
    output logic [NSLV*bus_pkg::DATA_W-1:0]     o_s_req_wdata,
    output logic [NSLV*bus_pkg::STRB_W-1:0]     o_s_req_wstrb,
    output logic [NSLV-1:0]                     o_s_resp_ready,
    input  logic [NSLV-1:0]                     i_s_req_ready,
    input  logic [NSLV-1:0]                     i_s_resp_valid,
    input  logic [NSLV*bus_pkg::DATA_W-1:0]     i_s_resp_rdata,
    input  logic [NSLV-1:0]                     i_s_resp_err
);

    localparam int ADDR_W = bus_pkg::ADDR_W;
    localparam int DATA_W = bus_pkg::DATA_W;
    localparam int STRB_W = bus_pkg::STRB_W;

    logic [ADDR_W-1:0]         dec_addr;
    logic [$clog2(NSLV+1)-1:0] dec_sidx;

    bus_chan_if mst_if [NMST] ();
    // Extra entry for the default slave
    bus_chan_if slv_if [NSLV+1] ();

    for (genvar m = 0; m < NMST; m++) begin : g_mst
        assign mst_if[m].req_valid  = i_m_req_valid[m];
        assign mst_if[m].req_write  = i_m_req_write[m];
        assign mst_if[m].req_addr   = i_m_req_addr[m*ADDR_W +: ADDR_W];
        assign mst_if[m].req_wdata  = i_m_req_wdata[m*DATA_W +: DATA_W];
        assign mst_if[m].req_wstrb  = i_m_req_wstrb[m*STRB_W +: STRB_W];
        assign mst_if[m].resp_ready = i_m_resp_ready[m];
        assign o_m_req_ready[m]     = mst_if[m].req_ready;
        assign o_m_resp_valid[m]    = mst_if[m].resp_valid;
        assign o_m_resp_rdata[m*DATA_W +: DATA_W] = mst_if[m].resp_rdata;
        assign o_m_resp_err[m]      = mst_if[m].resp_err;
    end

    for (genvar s = 0; s < NSLV; s++) begin : g_slv
        assign o_s_req_valid[s]     = slv_if[s].req_valid;
        assign o_s_req_write[s]     = slv_if[s].req_write;
        assign o_s_req_addr[s*ADDR_W +: ADDR_W]  = slv_if[s].req_addr;
        assign o_s_req_wdata[s*DATA_W +: DATA_W] = slv_if[s].req_wdata;
        assign o_s_req_wstrb[s*STRB_W +: STRB_W] = slv_if[s].req_wstrb;
        assign o_s_resp_ready[s]    = slv_if[s].resp_ready;
        assign slv_if[s].req_ready  = i_s_req_ready[s];
        assign slv_if[s].resp_valid = i_s_resp_valid[s];
        assign slv_if[s].resp_rdata = i_s_resp_rdata[s*DATA_W +: DATA_W];
        assign slv_if[s].resp_err   = i_s_resp_err[s];
    end

    bus_addr_decode #(
        .NMST  (NMST),
        .NSLV  (NSLV),
        .P_MAP (P_MAP)
    ) u_decode (
        .i_addr (dec_addr),
        .o_sidx (dec_sidx)
    );

    bus_route_ctrl #(
        .NMST (NMST),
        .NSLV (NSLV)
    ) u_route (
        .i_clk      (i_clk),
        .i_nrst     (i_nrst),
        .i_mst      (mst_if),
        .o_slv      (slv_if),
        .o_req_addr (dec_addr),
        .i_sidx     (dec_sidx)
    );

    bus_miss_resp #(
        .NMST (NMST),
        .NSLV (NSLV)
    ) u_miss (
        .i_clk  (i_clk),
        .i_nrst (i_nrst),
        .i_req  (slv_if[NSLV])
    );

endmodule

// ==== tb_bus_xbar_tests.svh ====
// One single-beat transfer from master m, returns after the response fire
task automatic bus_access(input int m, input logic wr, input logic [31:0] addr,
                          input logic [31:0] wdata, output logic [31:0] rdata,
                          output logic err);
    int waited;
    waited = 0;
    rdata  = 'x;
    err    = 1'bx;
    @(posedge clk);
    m_req_valid[m] <= 1'b1;
    m_req_write[m] <= wr;
    m_addr[m]      <= addr;
    m_wdata[m]     <= wdata;
    @(negedge clk);
    while (!m_req_ready[m] && waited < WAIT_LIMIT) begin
        @(negedge clk);
        waited++;
    end
    if (m_req_ready[m]) begin
        @(posedge clk);
        m_req_valid[m] <= 1'b0;
        @(negedge clk);
        while (!(m_resp_valid[m] && m_resp_ready[m]) && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
    end
    if (m_resp_valid[m] && m_resp_ready[m]) begin
        rdata = m_resp_rdata[m*32 +: 32];
        err   = m_resp_err[m];
        @(posedge clk);
    end else begin
        $display("Master %0d: no response received for address %h at time %0t",
                 m, addr, $time);
        err_cnt++;
        m_req_valid[m] <= 1'b0;
    end
endtask

task automatic test_rw_each_slave();
    logic [31:0] addrs [3] = '{32'h0000_0010, 32'h0001_0020, 32'h8000_0040};
    logic [31:0] wd;
    logic [31:0] rd;
    logic        e;
    int          start;
    start = err_cnt;
    for (int s = 0; s < 3; s++) begin
        wd = $random(seed);
        bus_access(0, 1'b1, addrs[s], wd, rd, e);
        check_value(32'(e), 32'h0, "write error flag");
        bus_access(0, 1'b0, addrs[s], 32'h0, rd, e);
        check_value(rd, wd, "read back data");
        check_value(32'(e), 32'h0, "read error flag");
    end
    close_test("write and read back per slave", start);
endtask

task automatic test_miss_access();
    logic [31:0] rd;
    logic        e;
    int          start;
    start = err_cnt;
    miss_watch = 1'b1;
    bus_access(0, 1'b0, 32'h4000_0000, 32'h0, rd, e);
    check_value(rd, 32'hffff_ffff, "miss read data");
    check_value(32'(e), 32'h1, "miss read error flag");
    bus_access(0, 1'b1, 32'h4000_0000, $random(seed), rd, e);
    check_value(32'(e), 32'h1, "miss write error flag");
    miss_watch = 1'b0;
    close_test("miss access", start);
endtask

task automatic test_arbitration();
    logic [31:0] d0, d1, rd0, rd1;
    logic        e0, e1;
    time         t0, t1;
    int          start;
    start = err_cnt;
    d0 = $random(seed);
    d1 = $random(seed);
    fork
        begin
            bus_access(0, 1'b1, 32'h0000_0100, d0, rd0, e0);
            t0 = $time;
        end
        begin
            bus_access(1, 1'b1, 32'h0001_0100, d1, rd1, e1);
            t1 = $time;
        end
    join
    check_value(32'(t1 < t0), 32'h1, "master 1 served first");
    bus_access(0, 1'b0, 32'h0000_0100, 32'h0, rd0, e0);
    check_value(rd0, d0, "master 0 data after arbitration");
    bus_access(1, 1'b0, 32'h0001_0100, 32'h0, rd1, e1);
    check_value(rd1, d1, "master 1 data after arbitration");
    close_test("arbitration", start);
endtask

task automatic test_req_backpressure();
    logic [31:0] wd, rd;
    logic        e;
    int          start;
    start = err_cnt;
    wd = $random(seed);
    @(posedge clk);
    stall[1] <= 1'b1;
    @(posedge clk);
    fork
        bus_access(0, 1'b1, 32'h0001_0200, wd, rd, e);
        begin
            // Same edge on which the master raises its request
            @(posedge clk);
            repeat (5) begin
                @(negedge clk);
                check_value(32'(m_req_ready[0]), 32'h0, "req_ready while slave stalls");
                check_value(32'(s_req_valid[1]), 32'h1, "request held at slave 1");
            end
            @(posedge clk);
            stall[1] <= 1'b0;
        end
    join
    bus_access(0, 1'b0, 32'h0001_0200, 32'h0, rd, e);
    check_value(rd, wd, "data after request stall");
    close_test("request back-pressure", start);
endtask

task automatic test_resp_backpressure();
    logic [31:0] d0, d1, rd0, rd1;
    logic        e0, e1;
    time         t0, t1;
    int          start;
    start = err_cnt;
    d0 = $random(seed);
    d1 = $random(seed);
    bus_access(0, 1'b1, 32'h0000_0300, d0, rd0, e0);
    @(posedge clk);
    m_resp_ready[0] <= 1'b0;
    fork
        begin
            bus_access(0, 1'b0, 32'h0000_0300, 32'h0, rd0, e0);
            t0 = $time;
        end
        begin
            repeat (2) @(posedge clk);
            bus_access(1, 1'b1, 32'h8000_0080, d1, rd1, e1);
            t1 = $time;
        end
        begin
            repeat (4) @(negedge clk);
            repeat (4) begin
                @(negedge clk);
                check_value(32'(m_resp_valid[0]), 32'h1, "response held for master 0");
                check_value(32'(m_req_ready[1]), 32'h0, "master 1 blocked by owner");
            end
            @(posedge clk);
            m_resp_ready[0] <= 1'b1;
        end
    join
    check_value(rd0, d0, "held response data");
    check_value(32'(t0 < t1), 32'h1, "master 1 completes after master 0");
    bus_access(1, 1'b0, 32'h8000_0080, 32'h0, rd1, e1);
    check_value(rd1, d1, "master 1 data after response stall");
    close_test("response back-pressure", start);
endtask

task automatic test_page_boundary();
    logic [31:0] d0, d1, rd;
    logic        e;
    int          start;
    start = err_cnt;
    d0 = $random(seed);
    d1 = $random(seed);
    bus_access(0, 1'b1, 32'h0000_fffc, d0, rd, e);
    bus_access(0, 1'b1, 32'h0001_0000, d1, rd, e);
    check_value(mem[0][63], d0, "slave 0 holds last word of its window");
    check_value(mem[1][0], d1, "slave 1 holds first word of its window");
    bus_access(0, 1'b0, 32'h0000_fffc, 32'h0, rd, e);
    check_value(rd, d0, "read below page boundary");
    bus_access(0, 1'b0, 32'h0001_0000, 32'h0, rd, e);
    check_value(rd, d1, "read at page boundary");
    close_test("page boundary decode", start);
endtask

// ==== tb_bus_xbar.sv ====
module tb_bus_xbar;

    localparam int NMST       = 2;
    localparam int NSLV       = 3;
    localparam int MAX_CYCLES = 2000;
    localparam int WAIT_LIMIT = 40;

    logic               clk;
    logic               nrst;

    // Master side
    logic [NMST-1:0]    m_req_valid;
    logic [NMST-1:0]    m_req_write;
    logic [31:0]        m_addr  [NMST];
    logic [31:0]        m_wdata [NMST];
    logic [NMST-1:0]    m_resp_ready;
    logic [NMST-1:0]    m_req_ready;
    logic [NMST-1:0]    m_resp_valid;
    logic [NMST*32-1:0] m_resp_rdata;
    logic [NMST-1:0]    m_resp_err;

    // Slave side
    logic [NSLV-1:0]    s_req_valid;
    logic [NSLV-1:0]    s_req_write;
    logic [NSLV*32-1:0] s_req_addr;
    logic [NSLV*32-1:0] s_req_wdata;
    logic [NSLV*4-1:0]  s_req_wstrb;
    logic [NSLV-1:0]    s_resp_ready;
    logic [NSLV-1:0]    s_req_ready;
    logic [NSLV-1:0]    s_resp_valid;
    logic [NSLV*32-1:0] s_resp_rdata;
    logic [NSLV-1:0]    s_resp_err;

    // Slave models
    logic [31:0]        mem [NSLV][64];
    logic [NSLV-1:0]    stall;

    logic               miss_watch;
    integer             seed = 32'h01e580d6;
    int                 err_cnt;
    int                 tests_run;
    int                 tests_failed;
    int                 cycles;

    bus_xbar_top #(
        .NMST (NMST),
        .NSLV (NSLV)
    ) uut (
        .i_clk          (clk),
        .i_nrst         (nrst),
        .i_m_req_valid  (m_req_valid),
        .i_m_req_write  (m_req_write),
        .i_m_req_addr   ({m_addr[1], m_addr[0]}),
        .i_m_req_wdata  ({m_wdata[1], m_wdata[0]}),
        .i_m_req_wstrb  ({NMST{4'hf}}),
        .i_m_resp_ready (m_resp_ready),
        .o_m_req_ready  (m_req_ready),
        .o_m_resp_valid (m_resp_valid),
        .o_m_resp_rdata (m_resp_rdata),
        .o_m_resp_err   (m_resp_err),
        .o_s_req_valid  (s_req_valid),
        .o_s_req_write  (s_req_write),
        .o_s_req_addr   (s_req_addr),
        .o_s_req_wdata  (s_req_wdata),
        .o_s_req_wstrb  (s_req_wstrb),
        .o_s_resp_ready (s_resp_ready),
        .i_s_req_ready  (s_req_ready),
        .i_s_resp_valid (s_resp_valid),
        .i_s_resp_rdata (s_resp_rdata),
        .i_s_resp_err   (s_resp_err)
    );

    always #50 clk = ~clk;

    // Byte lanes with strobe set take the new data
    function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                                input logic [31:0] new_word,
                                                input logic [3:0]  strb);
        logic [31:0] word;
        word = old_word;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                word[b*8 +: 8] = new_word[b*8 +: 8];
            end
        end
        return word;
    endfunction

    // Each model answers one cycle after accepting, word index from addr[7:2]
    always @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            s_req_ready  <= '0;
            s_resp_valid <= '0;
            s_resp_rdata <= '0;
            s_resp_err   <= '0;
        end else begin
            for (int s = 0; s < NSLV; s++) begin
                if (s_req_valid[s] && s_req_ready[s]) begin
                    if (s_req_write[s]) begin
                        mem[s][s_req_addr[s*32+2 +: 6]] <=
                            merge_bytes(mem[s][s_req_addr[s*32+2 +: 6]],
                                        s_req_wdata[s*32 +: 32], s_req_wstrb[s*4 +: 4]);
                        s_resp_rdata[s*32 +: 32] <= s_req_wdata[s*32 +: 32];
                    end else begin
                        s_resp_rdata[s*32 +: 32] <= mem[s][s_req_addr[s*32+2 +: 6]];
                    end
                    s_resp_valid[s] <= 1'b1;
                    s_req_ready[s]  <= 1'b0;
                end else if (s_resp_valid[s] && s_resp_ready[s]) begin
                    s_resp_valid[s] <= 1'b0;
                    s_req_ready[s]  <= ~stall[s];
                end else if (!s_resp_valid[s]) begin
                    s_req_ready[s]  <= ~stall[s];
                end
            end
        end
    end

    // No mapped slave may see a request during a miss access
    always @(negedge clk) begin
        if (miss_watch) begin
            check_value(32'(s_req_valid), 32'h0, "slave request during miss access");
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout after %0d cycles, the run did not finish", cycles);
            $display("Test FAILED");
            $finish;
        end
    end

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
        if (got !== exp) begin
            $display("Error at time %0t: %s, got %h expected %h", $time, what, got, exp);
            err_cnt++;
        end
    endtask

    task automatic close_test(input string name, input int errs_at_start);
        tests_run++;
        if (err_cnt > errs_at_start) begin
            tests_failed++;
            $display("%s: fail", name);
        end else begin
            $display("%s: pass", name);
        end
    endtask

    `include "tb_bus_xbar_tests.svh"

    initial begin
        clk          = 1'b0;
        nrst         = 1'b0;
        m_req_valid  = '0;
        m_req_write  = '0;
        m_addr[0]    = '0;
        m_addr[1]    = '0;
        m_wdata[0]   = '0;
        m_wdata[1]   = '0;
        m_resp_ready = '1;
        stall        = '0;
        miss_watch   = 1'b0;
        err_cnt      = 0;
        tests_run    = 0;
        tests_failed = 0;
        cycles       = 0;
        repeat (5) @(posedge clk);
        nrst <= 1'b1;
        @(posedge clk);
        test_rw_each_slave();
        test_miss_access();
        test_arbitration();
        test_req_backpressure();
        test_resp_backpressure();
        test_page_boundary();
        $display("Tests run %0d, failed %0d, errors %0d, assertion failures %0d",
                 tests_run, tests_failed, err_cnt, uut.u_route.u_props.fail_cnt);
        if (tests_failed == 0 && uut.u_route.u_props.fail_cnt == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule
